// ==== source/scan_test_pkg.sv ====
// ----------------------------
// shared definitions for the scan chain test sequencer
// widths, sequencer state encoding and the packed buses
// used by the RTL and the testbench, always by scoped name
// ----------------------------
package scan_test_pkg;

  // ----------------------------
  // widths and sizes
  // ----------------------------
  // one sequencer period is 2**PHASE_WIDTH clock cycles
  localparam int PHASE_WIDTH     = 6;
  localparam int SCAN_LEN        = 16;
  // must be wide enough to hold SCAN_LEN itself
  localparam int SHIFT_CNT_WIDTH = 5;
  localparam int CAPTURE_DEPTH   = 16;

  // scan_load levels as seen by the chip
  localparam logic SCAN_MODE_SHIFT = 1'b0;
  localparam logic SCAN_MODE_LOAD  = 1'b1;

  // ----------------------------
  // sequencer states
  // ----------------------------
  typedef enum logic [3:0] {
    IDLE        = 4'd0,
    WAIT_TICK   = 4'd1,
    RESET_PULSE = 4'd2,
    TRIG_HIGH   = 4'd3,
    TRIG_LOW    = 4'd4,
    LOAD_DELAY  = 4'd5,
    LOAD_HIGH   = 4'd6,
    SHIFT_IN    = 4'd7,
    DONE        = 4'd8
  } seq_state_t;

  // ----------------------------
  // buses
  // ----------------------------
  // run settings, held stable by the host while req is high
  typedef struct packed {
    logic [PHASE_WIDTH-1:0] test_delay;
    logic [PHASE_WIDTH-1:0] trig_phase;
    logic [PHASE_WIDTH-1:0] scan_load_delay;
  } scan_test_cfg_t;

  // lines to the chip; reset_not is active low
  typedef struct packed {
    logic reset_not;
    logic trig_out;
    logic scan_load;
    logic scan_in;
  } asic_ctrl_t;

  typedef struct packed {
    logic dnn_out_0;
    logic dnn_out_1;
  } dnn_sample_t;

endpackage

// ==== source/phase_decode.sv ====
// ----------------------------
// free-running phase counter and phase strobes
// one period is 64 cycles; the strobes mark the step phase,
// two counts before it, and the trigger phase
// ----------------------------
`timescale 1ns/1ps

module phase_decode (
  input  logic                          clk,
  input  logic                          test_mask_reset_not,
  input  scan_test_pkg::scan_test_cfg_t cfg,
  output logic                          tick,
  output logic                          pre_tick,
  output logic                          trig_tick
);

  logic [scan_test_pkg::PHASE_WIDTH-1:0] phase_cnt;
  logic [scan_test_pkg::PHASE_WIDTH-1:0] pre_phase;

  // ----------------------------
  // phase counter
  // ----------------------------
  // wraps naturally at 2**PHASE_WIDTH
  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      phase_cnt <= '0;
    end else begin
      phase_cnt <= phase_cnt + 1'b1;
    end
  end

  // ----------------------------
  // strobes
  // ----------------------------
  // step phase minus two, modulo the period
  assign pre_phase = cfg.test_delay - scan_test_pkg::PHASE_WIDTH'(2);

  assign tick      = (phase_cnt == cfg.test_delay);
  // early by two so the shifter has settled by the step phase
  assign pre_tick  = (phase_cnt == pre_phase);
  assign trig_tick = (phase_cnt == cfg.trig_phase);

endmodule

// ==== source/scan_sequencer.sv ====
// ----------------------------
// test sequencer state machine
// runs one reset / trigger / scan-load / shift-in pass per host
// request and answers on the four-phase req/ack handshake
// every output is registered and moves with the state
// ----------------------------
`timescale 1ns/1ps

module scan_sequencer (
  input  logic                                      clk,
  input  logic                                      test_mask_reset_not,
  input  logic                                      req,
  output logic                                      ack,
  input  scan_test_pkg::scan_test_cfg_t             cfg,
  input  logic                                      tick,
  input  logic                                      pre_tick,
  input  logic                                      trig_tick,
  input  logic                                      bit0,
  input  logic [scan_test_pkg::SHIFT_CNT_WIDTH-1:0] shift_cnt,
  output logic                                      load_pattern,
  output logic                                      shift,
  output logic                                      clear,
  output logic                                      capture_en,
  output scan_test_pkg::asic_ctrl_t                 ctrl
);

  scan_test_pkg::seq_state_t             state;
  // periods spent in LOAD_DELAY, starting at one
  logic [scan_test_pkg::PHASE_WIDTH-1:0] delay_cnt;
  logic                                  shift_done;

  assign shift_done =
    (shift_cnt == scan_test_pkg::SHIFT_CNT_WIDTH'(scan_test_pkg::SCAN_LEN));

  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      state          <= scan_test_pkg::IDLE;
      delay_cnt      <= '0;
      ack            <= 1'b0;
      load_pattern   <= 1'b0;
      shift          <= 1'b0;
      clear          <= 1'b0;
      capture_en     <= 1'b0;
      ctrl.reset_not <= 1'b1;
      ctrl.trig_out  <= 1'b0;
      ctrl.scan_load <= scan_test_pkg::SCAN_MODE_LOAD;
      ctrl.scan_in   <= 1'b0;
    end else begin
      // strobes last one cycle unless set below
      load_pattern <= 1'b0;
      clear        <= 1'b0;
      shift        <= 1'b0;
      // scan data follows the shifter LSB one cycle late
      ctrl.scan_in <= bit0;

      case (state)
        scan_test_pkg::IDLE: begin
          // ack is always low here, so a new req can start a run
          if (req) begin
            state        <= scan_test_pkg::WAIT_TICK;
            load_pattern <= 1'b1;
            clear        <= 1'b1;
          end
        end

        scan_test_pkg::WAIT_TICK: begin
          if (tick) begin
            state          <= scan_test_pkg::RESET_PULSE;
            ctrl.reset_not <= 1'b0;
            ctrl.scan_load <= scan_test_pkg::SCAN_MODE_SHIFT;
          end
        end

        // chip reset held low for one full period
        scan_test_pkg::RESET_PULSE: begin
          if (tick) begin
            state          <= scan_test_pkg::TRIG_HIGH;
            ctrl.reset_not <= 1'b1;
          end
        end

        // ----------------------------
        // trigger pulse, one period wide at trig_phase
        // ----------------------------
        scan_test_pkg::TRIG_HIGH: begin
          if (trig_tick) begin
            ctrl.trig_out <= 1'b1;
          end
          if (tick) begin
            state <= scan_test_pkg::TRIG_LOW;
          end
        end

        scan_test_pkg::TRIG_LOW: begin
          if (trig_tick) begin
            ctrl.trig_out <= 1'b0;
          end
          if (tick) begin
            if (cfg.scan_load_delay == '0) begin
              state          <= scan_test_pkg::LOAD_HIGH;
              ctrl.scan_load <= scan_test_pkg::SCAN_MODE_LOAD;
              capture_en     <= 1'b1;
            end else begin
              state     <= scan_test_pkg::LOAD_DELAY;
              delay_cnt <= scan_test_pkg::PHASE_WIDTH'(1);
            end
          end
        end

        scan_test_pkg::LOAD_DELAY: begin
          if (tick) begin
            if (delay_cnt == cfg.scan_load_delay) begin
              state          <= scan_test_pkg::LOAD_HIGH;
              ctrl.scan_load <= scan_test_pkg::SCAN_MODE_LOAD;
              capture_en     <= 1'b1;
            end else begin
              delay_cnt <= delay_cnt + 1'b1;
            end
          end
        end

        // DNN outputs sampled while the comparators load
        scan_test_pkg::LOAD_HIGH: begin
          if (tick) begin
            state          <= scan_test_pkg::SHIFT_IN;
            ctrl.scan_load <= scan_test_pkg::SCAN_MODE_SHIFT;
            capture_en     <= 1'b0;
          end
        end

        // ----------------------------
        // serial shift-in, one bit per period
        // ----------------------------
        scan_test_pkg::SHIFT_IN: begin
          if (shift_done) begin
            state          <= scan_test_pkg::DONE;
            ctrl.scan_load <= scan_test_pkg::SCAN_MODE_LOAD;
            ack            <= 1'b1;
          end else if (pre_tick) begin
            shift <= 1'b1;
          end
        end

        // hold ack until the host drops req
        scan_test_pkg::DONE: begin
          if (!req) begin
            state <= scan_test_pkg::IDLE;
            ack   <= 1'b0;
          end
        end

        default: begin
          state <= scan_test_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// ==== source/scan_pattern_shifter.sv ====
// ----------------------------
// local scan pattern register
// loads the pattern at run start and shifts it right on each
// shift strobe, so bits leave LSB first; counts shifted bits
// ----------------------------
`timescale 1ns/1ps

module scan_pattern_shifter (
  input  logic                                      clk,
  input  logic                                      test_mask_reset_not,
  input  logic                                      load_pattern,
  input  logic [scan_test_pkg::SCAN_LEN-1:0]        pattern,
  input  logic                                      shift,
  output logic                                      bit0,
  output logic [scan_test_pkg::SHIFT_CNT_WIDTH-1:0] shift_cnt
);

  logic [scan_test_pkg::SCAN_LEN-1:0] pattern_q;

  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      pattern_q <= '0;
      shift_cnt <= '0;
    end else if (load_pattern) begin
      pattern_q <= pattern;
      shift_cnt <= '0;
    end else if (shift) begin
      // zero fill from the top
      pattern_q <= {1'b0, pattern_q[scan_test_pkg::SCAN_LEN-1:1]};
      shift_cnt <= shift_cnt + 1'b1;
    end
  end

  assign bit0 = pattern_q[0];

endmodule

// ==== source/dnn_capture.sv ====
// ----------------------------
// DNN output history
// shifts one sample per enabled cycle in at bit 0 and holds
// the last CAPTURE_DEPTH samples until the next clear
// ----------------------------
`timescale 1ns/1ps

module dnn_capture (
  input  logic                                    clk,
  input  logic                                    test_mask_reset_not,
  input  logic                                    clear,
  input  logic                                    capture_en,
  input  scan_test_pkg::dnn_sample_t              sample,
  output logic [scan_test_pkg::CAPTURE_DEPTH-1:0] history_0,
  output logic [scan_test_pkg::CAPTURE_DEPTH-1:0] history_1
);

  always_ff @(posedge clk) begin
    if (test_mask_reset_not || clear) begin
      history_0 <= '0;
      history_1 <= '0;
    end else if (capture_en) begin
      // newest sample at bit 0, oldest falls off the top
      history_0 <= {history_0[scan_test_pkg::CAPTURE_DEPTH-2:0], sample.dnn_out_0};
      history_1 <= {history_1[scan_test_pkg::CAPTURE_DEPTH-2:0], sample.dnn_out_1};
    end
  end

endmodule

// ==== source/scan_test_top.sv ====
// ----------------------------
// scan chain test sequencer, top level
// phase decode drives the sequencer, which steers the pattern
// shifter and the DNN capture; the chip lines leave as one bus
// ----------------------------
`timescale 1ns/1ps

module scan_test_top (
  input  logic                                    clk,
  input  logic                                    test_mask_reset_not,
  input  logic                                    req,
  output logic                                    ack,
  input  scan_test_pkg::scan_test_cfg_t           cfg,
  input  logic [scan_test_pkg::SCAN_LEN-1:0]      pattern,
  input  scan_test_pkg::dnn_sample_t              dnn_in,
  output scan_test_pkg::asic_ctrl_t               ctrl,
  output logic [scan_test_pkg::CAPTURE_DEPTH-1:0] history_0,
  output logic [scan_test_pkg::CAPTURE_DEPTH-1:0] history_1
);

  // phase strobes
  logic tick;
  logic pre_tick;
  logic trig_tick;

  // pattern shifter handshake
  logic                                      load_pattern;
  logic                                      shift;
  logic                                      bit0;
  logic [scan_test_pkg::SHIFT_CNT_WIDTH-1:0] shift_cnt;

  // capture control
  logic clear;
  logic capture_en;

  phase_decode phase_decode_i (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .cfg                 (cfg),
    .tick                (tick),
    .pre_tick            (pre_tick),
    .trig_tick           (trig_tick)
  );

  scan_sequencer scan_sequencer_i (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .req                 (req),
    .ack                 (ack),
    .cfg                 (cfg),
    .tick                (tick),
    .pre_tick            (pre_tick),
    .trig_tick           (trig_tick),
    .bit0                (bit0),
    .shift_cnt           (shift_cnt),
    .load_pattern        (load_pattern),
    .shift               (shift),
    .clear               (clear),
    .capture_en          (capture_en),
    .ctrl                (ctrl)
  );

  scan_pattern_shifter scan_pattern_shifter_i (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .load_pattern        (load_pattern),
    .pattern             (pattern),
    .shift               (shift),
    .bit0                (bit0),
    .shift_cnt           (shift_cnt)
  );

  dnn_capture dnn_capture_i (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .clear               (clear),
    .capture_en          (capture_en),
    .sample              (dnn_in),
    .history_0           (history_0),
    .history_1           (history_1)
  );

endmodule

// ==== bench/scan_test_tb.sv ====
// ------------------------------
// testbench for the scan chain test sequencer
// four host runs with random settings, patterns and DNN samples;
// a negedge monitor checks the handshake, the chip lines and the
// captured history against values worked out from the samples
// ------------------------------
`timescale 1ns/1ps

module scan_test_tb;

  localparam int RUNS = 4;
  // four runs of at most 26 periods of 64 cycles plus a wide margin
  localparam int TIMEOUT_CYCLES = 30000;

  logic                                    clk = 1'b0;
  logic                                    test_mask_reset_not;
  logic                                    req;
  logic                                    ack;
  scan_test_pkg::scan_test_cfg_t           cfg;
  logic [scan_test_pkg::SCAN_LEN-1:0]      pattern;
  scan_test_pkg::dnn_sample_t              dnn_in;
  scan_test_pkg::asic_ctrl_t               ctrl;
  logic [scan_test_pkg::CAPTURE_DEPTH-1:0] history_0;
  logic [scan_test_pkg::CAPTURE_DEPTH-1:0] history_1;

  logic [31:0] lfsr = 32'h75d6_a53c;
  int          errors = 0;
  int          timeout_cnt = 0;
  int          runs_done = 0;

  // ------------------------------
  // monitor state
  // ------------------------------
  scan_test_pkg::asic_ctrl_t          prev_ctrl;
  logic                               prev_ack;
  logic                               prev_req;
  int unsigned                        cyc;
  int unsigned                        reset_fall_at;
  int unsigned                        load_fall_at;
  int unsigned                        load_rise_at;
  int unsigned                        trig_rise_at;
  int unsigned                        exp_gap;
  // 0 idle, 1 after reset pulse start, 2 load window, 3 shifting
  int                                 run_step;
  int                                 resets_seen;
  int                                 trigs_seen;
  int                                 shifts_seen;
  logic                               reset_done;
  logic [scan_test_pkg::SCAN_LEN-1:0] pattern_rest;
  scan_test_pkg::dnn_sample_t         window_q[$];

  scan_test_top scan_test_top_i (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .req                 (req),
    .ack                 (ack),
    .cfg                 (cfg),
    .pattern             (pattern),
    .dnn_in              (dnn_in),
    .ctrl                (ctrl),
    .history_0           (history_0),
    .history_1           (history_1)
  );

  always #10 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------
  // galois LFSR stepped once per bit drawn
  function automatic logic rand_bit();
    logic out;
    out = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], rand_bit()};
    end
    return r;
  endfunction

  // last CAPTURE_DEPTH samples of the window with the newest at bit 0
  function automatic logic [scan_test_pkg::CAPTURE_DEPTH-1:0] expected_history(
    input logic which
  );
    logic [scan_test_pkg::CAPTURE_DEPTH-1:0] hist;
    int first;
    hist = '0;
    first = window_q.size() - scan_test_pkg::CAPTURE_DEPTH;
    if (first < 0) begin
      first = 0;
    end
    for (int i = first; i < window_q.size(); i++) begin
      hist = {hist[scan_test_pkg::CAPTURE_DEPTH-2:0],
              which ? window_q[i].dnn_out_1 : window_q[i].dnn_out_0};
    end
    return hist;
  endfunction

  task automatic stop_on_mismatch(input string name, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
    errors = errors + 1;
    $display("** Error run %0d %s: expected %0h, actual %0h",
             runs_done, name, exp_val, act_val);
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic stop_on_fault(input string what);
    errors = errors + 1;
    $display("error in run %0d: %s", runs_done, what);
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  always @(posedge clk) begin
    dnn_in.dnn_out_0 <= rand_bit();
    dnn_in.dnn_out_1 <= rand_bit();
  end

  initial begin
    scan_test_pkg::scan_test_cfg_t      next_cfg;
    logic [scan_test_pkg::SCAN_LEN-1:0] next_pattern;
    test_mask_reset_not = 1'b1;
    req = 1'b0;
    cfg = '0;
    pattern = '0;
    dnn_in = '0;
    repeat (3) @(posedge clk);
    test_mask_reset_not <= 1'b0;
    for (int run = 0; run < RUNS; run++) begin
      // drawn at the falling edge away from the dnn_in draws
      @(negedge clk);
      next_cfg.test_delay = scan_test_pkg::PHASE_WIDTH'(rand_bits(scan_test_pkg::PHASE_WIDTH));
      next_cfg.trig_phase = scan_test_pkg::PHASE_WIDTH'(rand_bits(scan_test_pkg::PHASE_WIDTH));
      if (run == 0) begin
        next_cfg.scan_load_delay = '0;
      end else begin
        next_cfg.scan_load_delay = scan_test_pkg::PHASE_WIDTH'(rand_bits(2));
      end
      next_pattern = scan_test_pkg::SCAN_LEN'(rand_bits(scan_test_pkg::SCAN_LEN));
      @(posedge clk);
      cfg <= next_cfg;
      pattern <= next_pattern;
      req <= 1'b1;
      @(posedge clk);
      while (!ack) @(posedge clk);
      req <= 1'b0;
      @(posedge clk);
      while (ack) @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  always @(posedge clk) begin
    timeout_cnt <= timeout_cnt + 1;
    if (timeout_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the runs did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $fatal(1, "simulation stopped by the timeout");
    end
  end

  // ------------------------------
  // compare process
  // ------------------------------
  // outputs sampled mid-cycle where they hold the value the next rising edge sees
  always @(negedge clk) begin
    if (test_mask_reset_not) begin
      assert (!ack && ctrl.scan_load == scan_test_pkg::SCAN_MODE_LOAD && ctrl.reset_not)
        else stop_on_fault("ack, scan_load or reset_not wrong during reset");
      cyc = 0;
      run_step = 0;
      resets_seen = 0;
      trigs_seen = 0;
      shifts_seen = 0;
      reset_done = 1'b0;
      window_q.delete();
    end else begin
      cyc = cyc + 1;
      if (prev_ack && prev_req) begin
        assert (ack) else stop_on_fault("ack dropped while req was still high");
      end
      if (prev_ack && !prev_req) begin
        assert (!ack) else stop_on_fault("ack stayed high after req fell");
      end
      // chip reset pulse starts the run
      if (prev_ctrl.reset_not && !ctrl.reset_not) begin
        assert (prev_ctrl.scan_load && !ctrl.scan_load)
          else stop_on_fault("scan_load did not fall with reset_not");
        resets_seen++;
        reset_done = 1'b0;
        reset_fall_at = cyc;
        load_fall_at = cyc;
        run_step = 1;
      end
      if (!prev_ctrl.reset_not && ctrl.reset_not) begin
        assert (cyc - reset_fall_at == 64)
          else stop_on_mismatch("reset_pulse_width", 64, cyc - reset_fall_at);
        reset_done = 1'b1;
      end
      if (!prev_ctrl.trig_out && ctrl.trig_out) begin
        assert (reset_done && ctrl.reset_not)
          else stop_on_fault("trig_out rose before the reset pulse ended");
        trigs_seen++;
        trig_rise_at = cyc;
      end
      if (prev_ctrl.trig_out && !ctrl.trig_out) begin
        assert (cyc - trig_rise_at == 64)
          else stop_on_mismatch("trigger_width", 64, cyc - trig_rise_at);
      end
      if (!prev_ctrl.scan_load && ctrl.scan_load && run_step == 1) begin
        exp_gap = (32'd3 + 32'(cfg.scan_load_delay)) * 32'd64;
        assert (cyc - load_fall_at == exp_gap)
          else stop_on_mismatch("scan_load_delay", exp_gap, cyc - load_fall_at);
        load_rise_at = cyc;
        run_step = 2;
      end
      if (prev_ctrl.scan_load && !ctrl.scan_load && run_step == 2) begin
        assert (cyc - load_rise_at == 64)
          else stop_on_mismatch("scan_load_width", 64, cyc - load_rise_at);
        run_step = 3;
      end
      // the DUT takes this sample on the next rising edge
      if (run_step == 2 && ctrl.scan_load) begin
        window_q.push_back(dnn_in);
      end
      if (scan_test_top_i.shift) begin
        assert (run_step == 3 && shifts_seen < scan_test_pkg::SCAN_LEN)
          else stop_on_fault("shift strobe outside the shift phase");
        pattern_rest = pattern >> shifts_seen;
        assert (ctrl.scan_in == pattern_rest[0])
          else stop_on_mismatch("scan_in_bit", 32'(pattern_rest[0]), 32'(ctrl.scan_in));
        shifts_seen++;
      end
      // end of run
      if (ack && !prev_ack) begin
        assert (req) else stop_on_fault("ack rose while req was low");
        assert (shifts_seen == scan_test_pkg::SCAN_LEN)
          else stop_on_mismatch("shift_count", scan_test_pkg::SCAN_LEN, shifts_seen);
        assert (resets_seen == 1) else stop_on_mismatch("reset_pulses", 1, resets_seen);
        assert (trigs_seen == 1) else stop_on_mismatch("trigger_pulses", 1, trigs_seen);
        assert (!ctrl.trig_out) else stop_on_fault("trig_out still high when ack rose");
        assert (history_0 == expected_history(1'b0))
          else stop_on_mismatch("history_0", 32'(expected_history(1'b0)), 32'(history_0));
        assert (history_1 == expected_history(1'b1))
          else stop_on_mismatch("history_1", 32'(expected_history(1'b1)), 32'(history_1));
        runs_done++;
        run_step = 0;
        resets_seen = 0;
        trigs_seen = 0;
        shifts_seen = 0;
        window_q.delete();
      end
    end
    prev_ctrl = ctrl;
    prev_ack = ack;
    prev_req = req;
  end

endmodule

// ==== verilog.f ====
source/scan_test_pkg.sv
source/phase_decode.sv
source/scan_sequencer.sv
source/scan_pattern_shifter.sv
source/dnn_capture.sv
source/scan_test_top.sv
bench/scan_test_tb.sv

// ==== Makefile ====
TOP = scan_test_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) --Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
